//--- all.f
+incdir+tests
src/hypot_pkg.sv
src/sum_of_squares.sv
src/isqrt_seq.sv
src/magnitude_seq.sv
src/tt_um_addon.sv
tests/tb_hypot.sv

//--- run.sh
#!/bin/sh
# Build and run the magnitude testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_hypot -o tb_hypot \
    && ./obj_dir/tb_hypot 2>&1 | tee sim.log \
    && grep -q "^ALL CHECKS PASSED$" sim.log \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }

//--- src/hypot_pkg.sv
`default_nettype none

package hypot_pkg;

    // One vector component on ui_in or uio_in
    localparam int operand_w = 8;

    // 2 * 255^2 = 130050 needs 17 bits
    localparam int sum_w = 17;

    // Full root of the largest sum is 360
    localparam int root_w = 9;

    // One result bit per iteration
    localparam int iter_n = root_w;

    // Displayed byte on uo_out
    localparam int out_w = 8;

    // One sampled vector
    typedef struct packed {
        logic [operand_w-1:0] x;  // Component from ui_in
        logic [operand_w-1:0] y;  // Component from uio_in
    } operand_t;

    // Square of a single component
    typedef logic [2*operand_w-1:0] sq_t;

    // Sum of both squares, never overflows
    typedef logic [sum_w-1:0] sum_t;

    // Integer square root of sum_t
    typedef logic [root_w-1:0] root_t;

    // Magnitude as shown on the output pins
    typedef logic [out_w-1:0] out_t;

    // Roots above this are clamped
    localparam out_t out_max = 8'd255;

endpackage

`default_nettype wire

//--- src/isqrt_seq.sv
`timescale 1ns/1ps
`default_nettype none

// Restoring digit-by-digit square root, one root bit per clock
module isqrt_seq (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             start,     // Load radicand, begin a run
    input  wire hypot_pkg::sum_t radicand,
    output logic            done,      // One-cycle strobe, root is valid
    output hypot_pkg::root_t root
);

    // Radicand padded to an even bit count, two bits per step
    typedef logic [2*hypot_pkg::iter_n-1:0] rad_t;

    // Remainder never exceeds 2 * root, plus room for the shift
    typedef logic [hypot_pkg::root_w+2:0] rem_t;

    typedef logic [$clog2(hypot_pkg::iter_n+1)-1:0] cnt_t;

    logic             busy_q;
    cnt_t             cnt_q;     // Steps left in this run
    logic             done_q;
    rad_t             rad_q;     // Unconsumed radicand bits, MSBs first
    rem_t             rem_q;
    hypot_pkg::root_t root_q;

    rem_t rem_shift;
    rem_t trial;
    rem_t diff;
    logic fits;

    // One restoring step, all from registered state
    always_comb begin
        rem_shift = {rem_q[hypot_pkg::root_w:0], rad_q[2*hypot_pkg::iter_n-1 -: 2]};
        trial     = {1'b0, root_q, 2'b01};  // 4 * root + 1
        diff      = rem_shift - trial;
        fits      = (rem_shift >= trial);   // Keep the subtraction only if non-negative
    end

    // Run control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= cnt_t'(hypot_pkg::iter_n);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == cnt_t'(1)) begin  // Last step lands with done
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            rad_q  <= rad_t'(radicand);
            rem_q  <= '0;
            root_q <= '0;
        end else if (busy_q) begin
            rad_q  <= {rad_q[2*hypot_pkg::iter_n-3:0], 2'b00};
            rem_q  <= fits ? diff : rem_shift;
            // Top bit is still zero until the final step
            root_q <= {root_q[hypot_pkg::root_w-2:0], fits};
        end
    end

    assign done = done_q;
    assign root = root_q;

    a_done_pulse : assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    ) else $error("done held longer than one cycle");

    // Upstream must never restart a run in progress
    a_no_start_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        busy_q |-> !start
    ) else $error("start while root unit busy");

endmodule

`default_nettype wire

//--- src/magnitude_seq.sv
`timescale 1ns/1ps
`default_nettype none

// Starts conversions while enabled, keeps one in flight, holds the result
module magnitude_seq (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              ena,
    output logic             sample,     // Capture inputs at this edge
    input  wire              done,       // Root ready from the root unit
    input  wire hypot_pkg::root_t root,
    output hypot_pkg::out_t  magnitude
);

    logic            busy_q;
    hypot_pkg::out_t mag_q;
    hypot_pkg::out_t clamped;

    // New conversion only when idle, a running one ignores ena
    assign sample = ena && !busy_q;

    // Saturate 9-bit root to the output byte
    always_comb begin
        if (root > hypot_pkg::root_t'(hypot_pkg::out_max)) begin
            clamped = hypot_pkg::out_max;
        end else begin
            clamped = hypot_pkg::out_t'(root);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            mag_q  <= '0;
        end else begin
            if (sample) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
                mag_q  <= clamped;  // Held until the next done
            end
        end
    end

    assign magnitude = mag_q;

    // Root unit only finishes conversions this block started
    a_done_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> busy_q
    ) else $error("done seen while sequencer idle");

endmodule

`default_nettype wire

//--- src/sum_of_squares.sv
`timescale 1ns/1ps
`default_nettype none

// Two-stage pipeline: squares on the sample edge, sum one edge later
module sum_of_squares (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  sample,     // Capture operand this edge
    input  wire hypot_pkg::operand_t operand,
    output logic                 sum_valid,  // One-cycle strobe, sum is valid
    output hypot_pkg::sum_t      sum
);

    hypot_pkg::sq_t  sq_x_q;
    hypot_pkg::sq_t  sq_y_q;
    logic            sq_valid_q;
    hypot_pkg::sum_t sum_q;
    logic            sum_valid_q;

    // Stage 1 valid and stage 2 valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sq_valid_q  <= 1'b0;
            sum_valid_q <= 1'b0;
        end else begin
            sq_valid_q  <= sample;
            sum_valid_q <= sq_valid_q;
        end
    end

    // Stage 1 squares, only loaded on a sample strobe
    always_ff @(posedge clk) begin
        if (sample) begin
            sq_x_q <= hypot_pkg::sq_t'(operand.x) * hypot_pkg::sq_t'(operand.x);
            sq_y_q <= hypot_pkg::sq_t'(operand.y) * hypot_pkg::sq_t'(operand.y);
        end
    end

    // Stage 2 sum, widened before the add so the carry is kept
    always_ff @(posedge clk) begin
        if (sq_valid_q) begin
            sum_q <= hypot_pkg::sum_t'(sq_x_q) + hypot_pkg::sum_t'(sq_y_q);
        end
    end

    assign sum       = sum_q;
    assign sum_valid = sum_valid_q;

    // Fixed two-cycle latency in both directions
    a_sample_to_valid : assert property (
        @(posedge clk) disable iff (!rst_n)
        sample |-> ##2 sum_valid
    ) else $error("sum_valid missing two cycles after sample");

    a_valid_from_sample : assert property (
        @(posedge clk) disable iff (!rst_n)
        sum_valid |-> $past(sample, 2)
    ) else $error("sum_valid without a sample two cycles earlier");

endmodule

`default_nettype wire

//--- src/tt_um_addon.sv
`timescale 1ns/1ps
`default_nettype none

// Vector magnitude tile: uo_out = min(255, isqrt(x^2 + y^2))
module tt_um_addon (
    input  wire [7:0] ui_in,    // x component
    input  wire [7:0] uio_in,   // y component
    output wire [7:0] uo_out,   // Saturated magnitude
    output wire [7:0] uio_out,
    output wire [7:0] uio_oe,   // All zero, uio pins are inputs
    input  wire       ena,
    input  wire       clk,
    input  wire       rst_n
);

    hypot_pkg::operand_t operand;
    logic                sample;
    logic                sum_valid;
    hypot_pkg::sum_t     sum;
    logic                done;
    hypot_pkg::root_t    root;
    hypot_pkg::out_t     magnitude;

    assign operand = '{x: ui_in, y: uio_in};

    sum_of_squares sum_of_squares_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample    (sample),
        .operand   (operand),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    // Sum strobe starts the root directly
    isqrt_seq isqrt_seq_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (sum_valid),
        .radicand (sum),
        .done     (done),
        .root     (root)
    );

    magnitude_seq magnitude_seq_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ena       (ena),
        .sample    (sample),
        .done      (done),
        .root      (root),
        .magnitude (magnitude)
    );

    assign uo_out  = magnitude;
    assign uio_out = 8'd0;
    assign uio_oe  = 8'd0;

endmodule

`default_nettype wire

//--- tests/tb_hypot_checks.svh
`ifndef TB_HYPOT_CHECKS_SVH
`define TB_HYPOT_CHECKS_SVH

// Floor of sqrt(x^2 + y^2) by counting up, then clamped to the output byte
function automatic hypot_pkg::out_t ref_magnitude(hypot_pkg::operand_t v);
    int s;
    int r;
    s = int'(v.x) * int'(v.x) + int'(v.y) * int'(v.y);
    r = 0;
    while ((r + 1) * (r + 1) <= s) begin
        r++;
    end
    if (r > int'(hypot_pkg::out_max)) begin
        r = int'(hypot_pkg::out_max);  // 255,255 would be 360
    end
    return hypot_pkg::out_t'(r);
endfunction

// Magnitude on uo_out
task automatic compare_out(string name, hypot_pkg::out_t got, hypot_pkg::out_t expected);
    if (got !== expected) begin
        $display("MISMATCH at %0t ns: %s = %0d, expected %0d", $time, name, got, expected);
        stop_with_failure();
    end
endtask

// Plain 8-bit tile pins
task automatic compare_byte(string name, logic [7:0] got, logic [7:0] expected);
    if (got !== expected) begin
        $display("MISMATCH at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got,
                 expected);
        stop_with_failure();
    end
endtask

// Builds one vector from two components
function automatic hypot_pkg::operand_t pack_operand(logic [7:0] x, logic [7:0] y);
    hypot_pkg::operand_t v;
    v.x = x;
    v.y = y;
    return v;
endfunction

`endif

//--- tests/tb_hypot.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hypot;

    localparam int clk_period    = 40;
    localparam int reset_cycles  = 10;
    localparam int conv_cycles   = 13;  // Sample to next sample with ena high
    localparam int result_edge   = 12;  // Sample edge to uo_out update
    localparam int hold_cycles   = 2 * conv_cycles;
    localparam int n_corner      = 5;
    localparam int n_random      = 40;
    localparam int n_vectors     = n_corner + n_random + 4;  // Plus pause and cadence vectors
    localparam int margin_cycles = 200;
    localparam longint timeout_ns =
        longint'(n_vectors) * hold_cycles * clk_period + longint'(margin_cycles) * clk_period;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    wire  [7:0] uo_out;
    wire  [7:0] uio_out;
    wire  [7:0] uio_oe;

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    `include "tb_hypot_checks.svh"

    tt_um_addon tt_um_addon_i (
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    initial begin
        #(timeout_ns);
        $display("Timeout after %0d ns, the run hung before finishing", timeout_ns);
        stop_with_failure();
    end

    // Only updates the pins, the caller picks the edge
    task automatic set_inputs(hypot_pkg::operand_t v);
        ui_in  <= v.x;
        uio_in <= v.y;
    endtask

    // Long enough for one full conversion of v at any phase
    task automatic hold_and_check(hypot_pkg::operand_t v, hypot_pkg::out_t expected);
        @(posedge clk);
        set_inputs(v);
        repeat (hold_cycles) @(posedge clk);
        @(negedge clk);
        compare_out("uo_out", uo_out, expected);
    endtask

    // Cycle model of the conversion cadence, checked at every falling edge
    initial begin : cadence_model
        logic                model_busy;
        int                  left;
        hypot_pkg::out_t     pending;
        hypot_pkg::out_t     exp_out;
        hypot_pkg::operand_t v;
        model_busy = 1'b0;
        left       = 0;
        pending    = '0;
        exp_out    = '0;
        forever begin
            @(negedge clk);
            compare_out("uo_out", uo_out, exp_out);
            compare_byte("uio_out", uio_out, 8'd0);
            compare_byte("uio_oe", uio_oe, 8'd0);
            // Predict what the coming rising edge does
            if (!rst_n) begin
                model_busy = 1'b0;
                exp_out    = '0;
            end else if (model_busy) begin
                left--;
                if (left == 0) begin
                    exp_out    = pending;
                    model_busy = 1'b0;
                end
            end else if (ena) begin
                v          = pack_operand(ui_in, uio_in);
                pending    = ref_magnitude(v);
                left       = result_edge;
                model_busy = 1'b1;
            end
        end
    end

    initial begin : stimulus
        hypot_pkg::operand_t v;
        hypot_pkg::operand_t a_vec;
        hypot_pkg::operand_t b_vec;
        hypot_pkg::operand_t c_vec;
        hypot_pkg::out_t     old_mag;
        void'($urandom(32'he4ca));
        rst_n    = 1'b0;
        ena      = 1'b0;
        ui_in    = 8'd0;
        uio_in   = 8'd0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        // Inputs move while ena is low, output stays at zero
        repeat (20) begin
            @(posedge clk);
            ui_in  <= 8'($urandom);
            uio_in <= 8'($urandom);
        end

        ena <= 1'b1;
        hold_and_check(pack_operand(8'd0, 8'd0), 8'd0);
        hold_and_check(pack_operand(8'd3, 8'd4), 8'd5);
        hold_and_check(pack_operand(8'd0, 8'd255), 8'd255);
        hold_and_check(pack_operand(8'd255, 8'd0), 8'd255);
        hold_and_check(pack_operand(8'd255, 8'd255), 8'd255);  // Saturated

        for (int i = 0; i < n_random; i++) begin
            v.x = 8'($urandom);
            v.y = 8'($urandom);
            hold_and_check(v, ref_magnitude(v));
        end

        // Drain with ena low, then start one conversion and pause it
        @(posedge clk);
        ena <= 1'b0;
        repeat (conv_cycles + 1) @(posedge clk);
        v = pack_operand(8'd6, 8'd8);
        set_inputs(v);
        ena <= 1'b1;
        @(posedge clk);                  // Sample edge
        repeat (3) @(posedge clk);
        ena <= 1'b0;                     // Mid-conversion
        repeat (12) begin
            repeat (3) @(posedge clk);
            ui_in  <= 8'($urandom);
            uio_in <= 8'($urandom);
        end
        @(negedge clk);
        compare_out("uo_out", uo_out, ref_magnitude(v));
        old_mag = ref_magnitude(v);

        // Cadence from the rise of ena
        a_vec = pack_operand(8'd5, 8'd12);
        b_vec = pack_operand(8'd8, 8'd15);
        c_vec = pack_operand(8'd20, 8'd21);
        @(posedge clk);
        set_inputs(a_vec);
        ena <= 1'b1;
        @(posedge clk);                  // First sample edge
        repeat (5) @(posedge clk);
        set_inputs(b_vec);               // Ignored until the next sample
        repeat (6) @(posedge clk);
        @(negedge clk);
        compare_out("uo_out", uo_out, old_mag);  // 11 edges after sample
        @(posedge clk);
        @(negedge clk);
        compare_out("uo_out", uo_out, ref_magnitude(a_vec));
        repeat (6) @(posedge clk);
        set_inputs(c_vec);
        repeat (6) @(posedge clk);
        @(negedge clk);
        compare_out("uo_out", uo_out, ref_magnitude(a_vec));
        @(posedge clk);
        @(negedge clk);
        compare_out("uo_out", uo_out, ref_magnitude(b_vec));  // 13 cycles later
        @(posedge clk);
        ena <= 1'b0;
        repeat (conv_cycles + 1) @(posedge clk);
        @(negedge clk);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
